/* list.f */
source/mac_tx_pkg.sv
source/tx_fetch.sv
source/tx_fifo.sv
source/mii_tx_serializer.sv
source/mac_tx_top.sv
dv/mac_tx_checker.sv
dv/mac_tx_tb.sv

/* Bender.yml */
package:
  name: mac_tx

sources:
  # package first, then the blocks, top level last
  - source/mac_tx_pkg.sv
  - source/tx_fetch.sv
  - source/tx_fifo.sv
  - source/mii_tx_serializer.sv
  - source/mac_tx_top.sv

  # testbench sources, checker before the tb top
  - target: test
    files:
      - dv/mac_tx_checker.sv
      - dv/mac_tx_tb.sv

/* dv/mac_tx_tb.sv */
//##########################################################################
// mac transmit testbench with clocks, bus memory model and frame stimulus
//##########################################################################

`timescale 1ns/1ps

module mac_tx_tb;

	import mac_tx_pkg::*;

	localparam int frame_count     = 8;
	localparam int min_frame_bytes = 64;
	localparam int max_frame_bytes = 300;
	localparam int mem_words       = 1024;
	localparam int gap_cycles      = 20;  // covers the can_tx sync lag
	// mii needs 80 ns a byte and a full fifo drains on top
	localparam int watchdog_ns =
		frame_count * (max_frame_bytes + 2 ** fifo_depth_log2) * 100 + 20000;

	logic        sys_clk = 1'b0;
	logic        phy_tx_clk = 1'b0;
	logic        sys_rst = 1'b1;
	logic        tx_rst = 1'b0;
	tx_req_t     req = '0;
	logic        tx_next;
	bus_req_t    bus;
	logic        bus_ack = 1'b0;
	logic [31:0] bus_dat = '0;
	mii_tx_t     mii;
	logic [31:0] mem [mem_words];
	logic        bus_busy = 1'b0;
	int          ack_wait = 0;    // cycles left before ack
	logic [7:0]  exp_byte;
	logic        drained;
	logic        check_fail;

	// lane 0 is the top byte of the word
	function automatic logic [7:0] lane_byte(input logic [31:0] word, input logic [1:0] lane);
		return word >> (8 * (3 - lane));
	endfunction

	assign exp_byte = lane_byte(mem[req.adr[9:0]], req.bytecount); // 1024-word memory

	initial begin
		forever #10 sys_clk = ~sys_clk;
	end

	initial begin
		forever #20 phy_tx_clk = ~phy_tx_clk; // mii rate
	end

	mac_tx_top mac_tx_top_inst (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.tx_rst_i     (tx_rst),
		.req_i        (req),
		.tx_next_o    (tx_next),
		.bus_o        (bus),
		.bus_ack_i    (bus_ack),
		.bus_dat_i    (bus_dat),
		.phy_tx_clk_i (phy_tx_clk),
		.mii_o        (mii)
	);

	mac_tx_checker mac_tx_checker_inst (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.req_i        (req),
		.tx_next_i    (tx_next),
		.bus_i        (bus),
		.bus_ack_i    (bus_ack),
		.fifo_full_i  (mac_tx_top_inst.fifo_full),
		.exp_byte_i   (exp_byte),
		.phy_tx_clk_i (phy_tx_clk),
		.mii_i        (mii),
		.drained_o    (drained),
		.fail_o       (check_fail)
	);

	// memory slave acks after 0 to 3 extra cycles
	always @(posedge sys_clk) begin
		if (sys_rst) begin
			bus_ack  <= 1'b0;
			bus_busy <= 1'b0;
		end else begin
			bus_ack <= 1'b0;
			if (bus.cyc && bus.stb && !bus_ack) begin
				if (!bus_busy) begin
					bus_busy <= 1'b1;
					ack_wait <= $urandom_range(3, 0);
				end else if (ack_wait != 0) begin
					ack_wait <= ack_wait - 1;
				end else begin
					bus_ack  <= 1'b1;
					bus_dat  <= mem[bus.adr[11:2]]; // data only in the ack cycle
					bus_busy <= 1'b0;
				end
			end
		end
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1, "run stopped");
	endtask

	// one byte per tx_next and frames start on a word boundary
	task automatic send_frame(input int len, input logic [29:0] base);
		for (int i = 0; i < len; i++) begin
			req.valid     <= 1'b1;
			req.adr       <= base + i[31:2];
			req.bytecount <= i[1:0];
			@(posedge sys_clk);
			while (tx_next !== 1'b1)
				@(posedge sys_clk);
		end
		req.valid <= 1'b0;
	endtask

	task automatic wait_for_drain();
		@(posedge sys_clk);
		while (drained !== 1'b1)
			@(posedge sys_clk);
		repeat (gap_cycles) @(posedge sys_clk); // interframe gap
	endtask

	task automatic pulse_tx_rst();
		tx_rst <= 1'b1;
		@(posedge sys_clk);
		tx_rst <= 1'b0;
		repeat (gap_cycles) @(posedge sys_clk);
	endtask

	always @(posedge check_fail)
		stop_with_failure("checker reported an error");

	initial begin : watchdog
		#(watchdog_ns);
		stop_with_failure("timeout, frames did not finish in time");
	end

	initial begin : stimulus
		int len;
		int base_word;
		void'($urandom(32'hc49));
		for (int i = 0; i < mem_words; i++)
			mem[i] = $urandom() ^ (i * 32'h0101_0101);
		repeat (4) @(posedge sys_clk);
		sys_rst <= 1'b0;
		repeat (12) @(posedge sys_clk);
		for (int f = 0; f < frame_count; f++) begin
			if (f == 0)
				len = min_frame_bytes; // exactly the start level
			else if (f == 1)
				len = max_frame_bytes;
			else
				len = $urandom_range(max_frame_bytes, min_frame_bytes);
			base_word = $urandom_range(mem_words - max_frame_bytes / 4 - 1, 0);
			send_frame(len, base_word[29:0]);
			wait_for_drain();
			if (f == 2 || f == 5)
				pulse_tx_rst(); // clear between frames
		end
		if (check_fail) begin
			stop_with_failure("checker flagged an error by the end of the run");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

/* dv/mac_tx_checker.sv */
//##########################################################################
// mac transmit checker that rebuilds mii bytes and checks the bus and flow rules
//##########################################################################

`timescale 1ns/1ps

module mac_tx_checker (
	input  logic                 sys_clk,
	input  logic                 sys_rst,
	input  mac_tx_pkg::tx_req_t  req_i,
	input  logic                 tx_next_i,
	input  mac_tx_pkg::bus_req_t bus_i,
	input  logic                 bus_ack_i,
	input  logic                 fifo_full_i,
	input  logic [7:0]           exp_byte_i,  // lane byte of the current request
	input  logic                 phy_tx_clk_i,
	input  mac_tx_pkg::mii_tx_t  mii_i,
	output logic                 drained_o,   // nothing pending and mii idle
	output logic                 fail_o
);

	import mac_tx_pkg::*;

	localparam int start_bytes = 64; // transmit start level

	logic [7:0] exp_q [$];           // bytes consumed but not yet on mii
	int         pushed = 0;
	int         popped = 0;
	int         frame_bytes = 0;     // tx_next pulses in the current frame
	int         settle_cnt = 0;
	logic       armed = 1'b0;        // phy side settled after reset
	logic       draining = 1'b0;
	logic       rst_q = 1'b1;
	logic       valid_q = 1'b0;
	logic       cyc_q = 1'b0;
	logic       ack_q = 1'b0;
	logic       have_lo = 1'b0;      // low nibble already seen
	logic [3:0] lo_nib;
	logic       err_sys = 1'b0;
	logic       err_phy = 1'b0;

	assign drained_o = (pushed == popped) && (mii_i.en === 1'b0) && !have_lo;
	assign fail_o    = err_sys | err_phy;

	always @(posedge sys_clk) begin : sys_side
		logic [31:0] want_adr;
		want_adr = {2'b00, req_i.adr} * 32'd4; // four bytes per word
		rst_q   <= sys_rst;
		valid_q <= req_i.valid;
		cyc_q   <= bus_i.cyc;
		ack_q   <= bus_ack_i;
		if (!sys_rst) begin
			// first cycle out of reset
			if (rst_q)
				assert (tx_next_i === 1'b0 && bus_i.cyc === 1'b0
					&& bus_i.stb === 1'b0) else begin
					$display("tx_next or bus cyc/stb not low after reset at %0t", $time);
					err_sys = 1'b1;
				end
			if (settle_cnt < 8)
				settle_cnt <= settle_cnt + 1;
			else
				armed <= 1'b1;
			if (bus_i.cyc || bus_i.stb) begin
				assert (bus_i.cyc === bus_i.stb && req_i.valid
					&& req_i.bytecount == 2'd0) else begin
					$display("bus cycle outside a lane 0 request at %0t", $time);
					err_sys = 1'b1;
				end
				assert (bus_i.adr === want_adr) else begin
					$display("Mismatch at %0t: bus_o.adr expected %h actual %h",
						$time, want_adr, bus_i.adr);
					err_sys = 1'b1;
				end
			end
			if (cyc_q && !ack_q)
				assert (bus_i.cyc === 1'b1 && bus_i.stb === 1'b1) else begin
					$display("bus cyc/stb dropped before ack at %0t", $time);
					err_sys = 1'b1;
				end
			if (req_i.valid && !valid_q)
				frame_bytes <= tx_next_i ? 1 : 0; // new frame
			else if (tx_next_i)
				frame_bytes <= frame_bytes + 1;
			if (valid_q && !req_i.valid)
				draining <= 1'b1;
			else if (drained_o)
				draining <= 1'b0;
			if (tx_next_i) begin
				assert (fifo_full_i !== 1'b1 && !draining) else begin
					$display("tx_next while fifo full or frame draining at %0t", $time);
					err_sys = 1'b1;
				end
				exp_q.push_back(exp_byte_i);
				pushed <= pushed + 1;
			end
		end
	end

	always @(posedge phy_tx_clk_i) begin : mii_side
		logic [7:0] got;
		logic [7:0] want;
		if (armed) begin
			// en must be clean and held back until the start level
			assert (mii_i.en === 1'b0 || frame_bytes >= start_bytes) else begin
				$display("mii en high or unknown before %0d bytes at %0t",
					start_bytes, $time);
				err_phy = 1'b1;
			end
			if (mii_i.en === 1'b1) begin
				if (!have_lo) begin
					lo_nib  <= mii_i.data; // low nibble goes first
					have_lo <= 1'b1;
				end else begin
					got = {mii_i.data, lo_nib};
					have_lo <= 1'b0;
					assert (exp_q.size() > 0) else begin
						$display("mii byte %02h with nothing expected at %0t", got, $time);
						err_phy = 1'b1;
					end
					if (exp_q.size() > 0) begin
						want = exp_q.pop_front();
						popped <= popped + 1;
						assert (got === want) else begin
							$display("Mismatch at %0t: mii_o byte expected %02h actual %02h",
								$time, want, got);
							err_phy = 1'b1;
						end
					end
				end
			end else begin
				assert (!have_lo) else begin
					$display("mii en dropped between two nibbles at %0t", $time);
					err_phy = 1'b1;
				end
			end
		end
	end

endmodule

/* source/mac_tx_top.sv */
//##########################################################################
// ethernet mac transmit path top, fetch into fifo into mii serializer
//##########################################################################

`timescale 1ns/1ps

module mac_tx_top (
	input  logic                 sys_clk,
	input  logic                 sys_rst,
	input  logic                 tx_rst_i,

	input  mac_tx_pkg::tx_req_t  req_i,
	output logic                 tx_next_o,

	output mac_tx_pkg::bus_req_t bus_o,
	input  logic                 bus_ack_i,
	input  logic [31:0]          bus_dat_i,

	input  logic                 phy_tx_clk_i,
	output mac_tx_pkg::mii_tx_t  mii_o
);

	// sys_clk side
	logic       wr_stb;
	logic [7:0] wr_data;
	logic       fifo_full;
	logic       fifo_empty;
	logic       can_tx;     // crosses inside the serializer

	// phy clock side
	logic       rd_stb;
	logic [7:0] rd_data;
	logic       rd_avail;

	tx_fetch tx_fetch_inst (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.req_i        (req_i),
		.tx_next_o    (tx_next_o),
		.bus_o        (bus_o),
		.bus_ack_i    (bus_ack_i),
		.bus_dat_i    (bus_dat_i),
		.fifo_full_i  (fifo_full),
		.fifo_empty_i (fifo_empty),
		.wr_stb_o     (wr_stb),
		.wr_data_o    (wr_data),
		.can_tx_o     (can_tx)
	);

	tx_fifo tx_fifo_inst (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.tx_rst_i     (tx_rst_i),
		.wr_stb_i     (wr_stb),
		.wr_data_i    (wr_data),
		.full_o       (fifo_full),
		.empty_o      (fifo_empty),
		.phy_tx_clk_i (phy_tx_clk_i),
		.rd_stb_i     (rd_stb),
		.rd_data_o    (rd_data),
		.rd_avail_o   (rd_avail)
	);

	mii_tx_serializer mii_tx_serializer_inst (
		.phy_tx_clk_i (phy_tx_clk_i),
		.sys_rst      (sys_rst),
		.can_tx_i     (can_tx),
		.rd_avail_i   (rd_avail),
		.rd_stb_o     (rd_stb),
		.rd_data_i    (rd_data),
		.mii_o        (mii_o)
	);

endmodule

/* source/mii_tx_serializer.sv */
//##########################################################################
// mii transmit serializer, one fifo byte out as two nibbles, low first
//##########################################################################

`timescale 1ns/1ps

module mii_tx_serializer (
	input  logic                phy_tx_clk_i,
	input  logic                sys_rst,
	input  logic                can_tx_i,     // sys domain level
	input  logic                rd_avail_i,
	output logic                rd_stb_o,
	input  logic [7:0]          rd_data_i,
	output mac_tx_pkg::mii_tx_t mii_o
);

	import mac_tx_pkg::*;

	logic [sync_stages-1:0] rst_sync;
	logic                   phy_rst;
	logic [sync_stages-1:0] can_tx_sync;
	logic                   can_tx_phy;

	logic       nib_phase;  // 1 = low nibble on the wire, high one next
	logic [3:0] hi_nib_q;
	logic       tx_en_q;
	logic [3:0] tx_data_q;

	// reset brought over into the phy clock
	always_ff @(posedge phy_tx_clk_i) begin
		rst_sync <= {rst_sync[sync_stages-2:0], sys_rst};
	end

	assign phy_rst = rst_sync[sync_stages-1];

	always_ff @(posedge phy_tx_clk_i) begin
		if (phy_rst)
			can_tx_sync <= '0;
		else
			can_tx_sync <= {can_tx_sync[sync_stages-2:0], can_tx_i};
	end

	assign can_tx_phy = can_tx_sync[sync_stages-1];

	// only fetch a new byte between nibble pairs
	assign rd_stb_o = ~nib_phase & can_tx_phy & rd_avail_i;

	always_ff @(posedge phy_tx_clk_i) begin
		if (phy_rst) begin
			nib_phase <= 1'b0;
			tx_en_q   <= 1'b0;
		end else if (nib_phase) begin
			nib_phase <= 1'b0; // second half of the byte
			tx_en_q   <= 1'b1;
		end else begin
			nib_phase <= rd_stb_o;
			tx_en_q   <= rd_stb_o; // en drops if the fifo ran dry
		end
	end

	always_ff @(posedge phy_tx_clk_i) begin
		if (rd_stb_o) begin
			tx_data_q <= rd_data_i[3:0];
			hi_nib_q  <= rd_data_i[7:4]; // kept for the next cycle
		end else if (nib_phase) begin
			tx_data_q <= hi_nib_q;
		end
	end

	assign mii_o = '{en: tx_en_q, data: tx_data_q};

endmodule

/* source/tx_fifo.sv */
//##########################################################################
// dual-clock byte fifo, writes on sys_clk and reads on the phy clock
// gray pointers cross in both directions, flags are conservative
//##########################################################################

`timescale 1ns/1ps

module tx_fifo (
	input  logic       sys_clk,
	input  logic       sys_rst,
	input  logic       tx_rst_i,    // clears the fifo between frames

	input  logic       wr_stb_i,
	input  logic [7:0] wr_data_i,
	output logic       full_o,
	output logic       empty_o,

	input  logic       phy_tx_clk_i,
	input  logic       rd_stb_i,
	output logic [7:0] rd_data_o,
	output logic       rd_avail_o   // phy-side not-empty
);

	import mac_tx_pkg::*;

	logic [7:0] mem [2**fifo_depth_log2];

	// pointers carry one extra wrap bit
	logic [fifo_depth_log2:0] wr_bin, wr_gray, wr_bin_nxt;
	logic [fifo_depth_log2:0] rd_bin, rd_gray, rd_bin_nxt;

	logic [sync_stages-1:0][fifo_depth_log2:0] rd_gray_sys; // rd ptr in sys domain
	logic [sync_stages-1:0][fifo_depth_log2:0] wr_gray_phy; // wr ptr in phy domain
	logic [fifo_depth_log2:0] rd_gray_s;
	logic [fifo_depth_log2:0] wr_gray_p;

	logic                   clr_sys;
	logic [2:0]             clr_cnt;   // stretches a short tx_rst pulse
	logic                   clr_busy;
	logic [sync_stages-1:0] clr_sync;
	logic                   clr_phy;
	logic                   wr_en;

	function automatic logic [fifo_depth_log2:0] to_gray(input logic [fifo_depth_log2:0] b);
		return b ^ (b >> 1);
	endfunction

	assign clr_sys  = sys_rst | tx_rst_i;
	assign clr_busy = clr_sys | (clr_cnt != 3'd0);

	// hold the clear long enough for a few phy edges
	always_ff @(posedge sys_clk) begin
		if (clr_sys)
			clr_cnt <= 3'd7;
		else if (clr_cnt != 3'd0)
			clr_cnt <= clr_cnt - 3'd1;
	end

	// write side, sys_clk
	assign wr_en      = wr_stb_i & ~full_o;
	assign wr_bin_nxt = wr_bin + 1'b1;
	assign rd_gray_s  = rd_gray_sys[sync_stages-1];

	always_ff @(posedge sys_clk) begin
		if (clr_busy) begin
			wr_bin      <= '0;
			wr_gray     <= '0;
			rd_gray_sys <= '0; // stale phy pointer must not leak through
		end else begin
			rd_gray_sys <= {rd_gray_sys[sync_stages-2:0], rd_gray};
			if (wr_en) begin
				wr_bin  <= wr_bin_nxt;
				wr_gray <= to_gray(wr_bin_nxt);
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr_en)
			mem[wr_bin[fifo_depth_log2-1:0]] <= wr_data_i;
	end

	// full: top two gray bits inverted, rest equal
	assign full_o = clr_busy
		| (wr_gray == {~rd_gray_s[fifo_depth_log2 -: 2], rd_gray_s[fifo_depth_log2-2:0]});
	assign empty_o = (wr_gray == rd_gray_s);

	// clear reaches the phy side through its own synchronizer
	always_ff @(posedge phy_tx_clk_i) begin
		clr_sync <= {clr_sync[sync_stages-2:0], clr_busy};
	end

	assign clr_phy = clr_sync[sync_stages-1];

	// read side, phy clock
	assign rd_bin_nxt = rd_bin + 1'b1;
	assign wr_gray_p  = wr_gray_phy[sync_stages-1];

	always_ff @(posedge phy_tx_clk_i) begin
		if (clr_phy) begin
			rd_bin      <= '0;
			rd_gray     <= '0;
			wr_gray_phy <= '0;
		end else begin
			wr_gray_phy <= {wr_gray_phy[sync_stages-2:0], wr_gray};
			if (rd_stb_i && rd_avail_o) begin
				rd_bin  <= rd_bin_nxt;
				rd_gray <= to_gray(rd_bin_nxt);
			end
		end
	end

	assign rd_avail_o = (rd_gray != wr_gray_p);
	assign rd_data_o  = mem[rd_bin[fifo_depth_log2-1:0]]; // head byte, async read

endmodule

/* source/tx_fetch.sv */
//##########################################################################
// transmit fetch: reads frame words from memory, feeds bytes to the fifo
// and gates transmission until 64 bytes are queued
//##########################################################################

`timescale 1ns/1ps

module tx_fetch (
	input  logic                  sys_clk,
	input  logic                  sys_rst,

	input  mac_tx_pkg::tx_req_t   req_i,
	output logic                  tx_next_o,   // consumes current byte

	output mac_tx_pkg::bus_req_t  bus_o,
	input  logic                  bus_ack_i,
	input  logic [31:0]           bus_dat_i,

	input  logic                  fifo_full_i,
	input  logic                  fifo_empty_i,
	output logic                  wr_stb_o,
	output logic [7:0]            wr_data_o,
	output logic                  can_tx_o     // level, crosses to phy side
);

	import mac_tx_pkg::*;

	typedef enum logic [1:0] {
		fetch_idle,
		fetch_bus,   // cyc/stb held until ack
		fetch_write  // byte from the new word goes out
	} fetch_state_t;

	typedef enum logic [1:0] {
		ctrl_idle,
		ctrl_waitfull,
		ctrl_tx,
		ctrl_purge
	} ctrl_state_t;

	fetch_state_t fetch_q, fetch_nxt;
	ctrl_state_t  ctrl_q, ctrl_nxt;

	logic [31:0]           word_q;    // last fetched word
	logic                  load_word;
	logic                  bus_req;
	logic                  first_byte;
	logic                  purge;     // blocks acceptance while draining
	logic                  clr_count;
	logic [tx_level_bit:0] byte_cnt;
	logic                  level_reached;

	assign first_byte = (req_i.bytecount == 2'd0);

	// word address to byte address
	assign bus_o = '{adr: {req_i.adr, 2'b00}, cyc: bus_req, stb: bus_req};

	always_ff @(posedge sys_clk) begin
		if (load_word)
			word_q <= bus_dat_i; // data only valid in the ack cycle
	end

	// big-endian lanes, lane 0 is the top byte
	always_comb begin
		unique case (req_i.bytecount)
			2'd0: wr_data_o = word_q[31:24];
			2'd1: wr_data_o = word_q[23:16];
			2'd2: wr_data_o = word_q[15:8];
			2'd3: wr_data_o = word_q[7:0];
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			fetch_q <= fetch_idle;
		else
			fetch_q <= fetch_nxt;
	end

	always_comb begin
		fetch_nxt = fetch_q;
		tx_next_o = 1'b0;
		wr_stb_o  = 1'b0;
		bus_req   = 1'b0;
		load_word = 1'b0;
		unique case (fetch_q)
			fetch_idle: begin
				if (req_i.valid && !fifo_full_i && !purge) begin
					if (first_byte) begin
						fetch_nxt = fetch_bus; // need a new word first
					end else begin
						wr_stb_o  = 1'b1; // lanes 1..3 come from word_q
						tx_next_o = 1'b1;
					end
				end
			end
			fetch_bus: begin
				bus_req = 1'b1;
				if (bus_ack_i) begin
					load_word = 1'b1;
					fetch_nxt = fetch_write;
				end
			end
			fetch_write: begin
				wr_stb_o  = 1'b1; // fifo was not full at acceptance
				tx_next_o = 1'b1;
				fetch_nxt = fetch_idle;
			end
			default: fetch_nxt = fetch_idle;
		endcase
	end

	// counts bytes written while waiting for the start level
	always_ff @(posedge sys_clk) begin
		if (sys_rst || clr_count)
			byte_cnt <= '0;
		else if (wr_stb_o)
			byte_cnt <= byte_cnt + 1'b1;
	end

	assign level_reached = byte_cnt[tx_level_bit];

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			ctrl_q <= ctrl_idle;
		else
			ctrl_q <= ctrl_nxt;
	end

	always_comb begin
		ctrl_nxt  = ctrl_q;
		can_tx_o  = 1'b0;
		purge     = 1'b0;
		clr_count = 1'b1;
		unique case (ctrl_q)
			ctrl_idle: begin
				if (req_i.valid)
					ctrl_nxt = ctrl_waitfull;
			end
			ctrl_waitfull: begin
				clr_count = 1'b0; // only state that counts
				if (level_reached)
					ctrl_nxt = ctrl_tx;
			end
			ctrl_tx: begin
				can_tx_o = 1'b1;
				if (!req_i.valid) begin
					purge    = 1'b1; // frame done, start draining
					ctrl_nxt = ctrl_purge;
				end
			end
			ctrl_purge: begin
				can_tx_o = 1'b1;
				purge    = 1'b1;
				// can_tx reaches the phy side late through its synchronizer,
				// the interframe gap absorbs that delay
				if (fifo_empty_i)
					ctrl_nxt = ctrl_idle;
			end
			default: ctrl_nxt = ctrl_idle;
		endcase
	end

endmodule

/* source/mac_tx_pkg.sv */
//##########################################################################
// mac transmit path shared definitions
// fifo sizing, sync depth and the bundled request/bus/mii types
//##########################################################################

package mac_tx_pkg;

	// fifo holds 128 bytes, the 64-byte start level plus headroom
	localparam int fifo_depth_log2 = 7;

	// byte counter bit that flags 64 bytes queued
	localparam int tx_level_bit = 6;

	// flops per clock-domain crossing
	localparam int sync_stages = 2;

	// one byte request from software
	typedef struct packed {
		logic        valid;     // held for the whole frame
		logic [29:0] adr;       // word address
		logic [1:0]  bytecount; // lane within the word, 0 = msb
	} tx_req_t;

	// master side of the memory read bus
	typedef struct packed {
		logic [31:0] adr; // byte address, always word aligned
		logic        cyc;
		logic        stb;
	} bus_req_t;

	// mii transmit pins
	typedef struct packed {
		logic       en;
		logic [3:0] data;
	} mii_tx_t;

endpackage
